//--- axi_rd_pkg.sv
/*
  AXI read-channel field widths and the vector types built on them.
  Only the AR and R fields used by the demux are described here.
  ID_WIDTH must not be smaller than the tracked ID bits of the demux.
*/

`default_nettype none

package axi_rd_pkg;

  // ------------------------------------------------------------------
  // field widths
  // ------------------------------------------------------------------
  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned LEN_WIDTH  = 8;

  // ------------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------------
  typedef logic [ID_WIDTH-1:0]   axi_id_t;
  typedef logic [ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [DATA_WIDTH-1:0] axi_data_t;
  // burst length minus one, as on the bus
  typedef logic [LEN_WIDTH-1:0]  axi_len_t;

endpackage

`default_nettype wire

//--- demux_cfg_pkg.sv
/*
  Sizing of the read demux: port count, tracked ID bits, counter width.
  A counter saturates at 2**CNT_WIDTH-1 reads in flight per tracked ID.
  Port selects at or above NUM_MST_PORTS reach no port.
*/

`default_nettype none

package demux_cfg_pkg;

  // ------------------------------------------------------------------
  // sizing
  // ------------------------------------------------------------------
  localparam int unsigned NUM_MST_PORTS = 3;
  localparam int unsigned SEL_WIDTH     = $clog2(NUM_MST_PORTS);
  // low ID bits that get a counter of their own
  localparam int unsigned ID_LOOK_BITS  = 2;
  localparam int unsigned NUM_COUNTERS  = 2 ** ID_LOOK_BITS;
  localparam int unsigned CNT_WIDTH     = 3;

  // ------------------------------------------------------------------
  // derived types
  // ------------------------------------------------------------------
  typedef logic [SEL_WIDTH-1:0]     port_sel_t;
  typedef logic [ID_LOOK_BITS-1:0]  look_id_t;
  typedef logic [NUM_MST_PORTS-1:0] port_mask_t;
  typedef logic [CNT_WIDTH-1:0]     in_flight_cnt_t;

endpackage

`default_nettype wire

//--- id_track_if.sv
/*
  Link between the AR router and the ID tracker.
  The push ID is the lookup ID, so a push always refers to the AR
  that was looked up in the same cycle.
*/

`timescale 1ns/1ps
`default_nettype none

interface id_track_if
  import demux_cfg_pkg::*;
();

  // tracker answers for the looked-up ID
  port_sel_t lookup_sel;
  logic      lookup_busy;
  logic      full;

  // router side
  look_id_t  lookup_id;
  logic      push;
  port_sel_t push_sel;

  modport tracker (
    input  lookup_id,
    input  push,
    input  push_sel,
    output lookup_sel,
    output lookup_busy,
    output full
  );

  modport router (
    output lookup_id,
    output push,
    output push_sel,
    input  lookup_sel,
    input  lookup_busy,
    input  full
  );

endinterface

`default_nettype wire

//--- demux_id_tracker.sv
/*
  Outstanding read counters, one per tracked ID, with the port each
  tracked ID was last sent to. Push and pop take effect at the next edge.
  A pop to an idle counter is not expected and would wrap it.
*/

`timescale 1ns/1ps
`default_nettype none

module demux_id_tracker
  import demux_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  id_track_if.tracker trk,
  input  logic     r_pop_i,
  input  look_id_t pop_id_i
);

  logic [NUM_COUNTERS-1:0] busy;
  logic [NUM_COUNTERS-1:0] saturated;
  // last select per tracked ID, only meaningful while busy
  port_sel_t               sel_q [NUM_COUNTERS];

  // ------------------------------------------------------------------
  // counters
  // ------------------------------------------------------------------
  for (genvar i = 0; i < NUM_COUNTERS; i++) begin : gen_cnt
    logic           up;
    logic           down;
    in_flight_cnt_t cnt_q;

    assign up   = trk.push && (trk.lookup_id == look_id_t'(i));
    assign down = r_pop_i && (pop_id_i == look_id_t'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else begin
        case ({up, down})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          // both or neither, count stays
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    assign busy[i]      = |cnt_q;
    assign saturated[i] = &cnt_q;
  end

  // ------------------------------------------------------------------
  // stored selects
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (trk.push) begin
      sel_q[trk.lookup_id] <= trk.push_sel;
    end
  end

  // lookup for the AR currently presented
  assign trk.lookup_sel  = sel_q[trk.lookup_id];
  assign trk.lookup_busy = busy[trk.lookup_id];
  // one full counter blocks every new AR
  assign trk.full        = |saturated;

endmodule

`default_nettype wire

//--- demux_ar_route.sv
/*
  AR steering with no register in the forward path.
  The upstream select and ID must stay stable while slv_ar_valid_i is high.
  Once a valid is shown to a port it stays up until that port accepts it.
*/

`timescale 1ns/1ps
`default_nettype none

module demux_ar_route
  import axi_rd_pkg::*;
  import demux_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  id_track_if.router trk,
  input  axi_id_t    slv_ar_id_i,
  input  port_sel_t  slv_ar_sel_i,
  input  logic       slv_ar_valid_i,
  output logic       slv_ar_ready_o,
  output port_mask_t mst_ar_valid_o,
  input  port_mask_t mst_ar_ready_i
);

  port_mask_t sel_onehot;
  logic       sel_ready;
  logic       ar_allowed;
  logic       fwd_valid;
  logic       handshake;
  logic       lock_q;

  // ------------------------------------------------------------------
  // tracker lookup and stall decision
  // ------------------------------------------------------------------
  assign trk.lookup_id = look_id_t'(slv_ar_id_i[ID_LOOK_BITS-1:0]);

  // same ID may only go on to the port it is already in flight to
  assign ar_allowed = !trk.full &&
                      (!trk.lookup_busy || (trk.lookup_sel == slv_ar_sel_i));

  // locked valid ignores the tracker, e.g. a full that came up meanwhile
  assign fwd_valid = lock_q || (slv_ar_valid_i && ar_allowed);

  // ------------------------------------------------------------------
  // steering
  // ------------------------------------------------------------------
  assign sel_onehot = port_mask_t'(1) << slv_ar_sel_i;
  assign sel_ready  = |(mst_ar_ready_i & sel_onehot);
  assign handshake  = fwd_valid && sel_ready;

  assign mst_ar_valid_o = fwd_valid ? sel_onehot : '0;
  assign slv_ar_ready_o = handshake;

  // every accepted AR is counted under its ID
  assign trk.push     = handshake;
  assign trk.push_sel = slv_ar_sel_i;

  // ------------------------------------------------------------------
  // valid lock
  // ------------------------------------------------------------------
  // set while a shown valid waits, cleared by the handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= fwd_valid && !sel_ready;
    end
  end

endmodule

`default_nettype wire

//--- demux_r_merge.sv
/*
  Round-robin merge of the R channels of all ports onto the upstream port.
  Valid to valid is combinational. A beat that waits for ready keeps
  its grant, so the upstream beat stays stable under back-pressure.
*/

`timescale 1ns/1ps
`default_nettype none

module demux_r_merge
  import axi_rd_pkg::*;
  import demux_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  axi_id_t    mst_r_id_i   [NUM_MST_PORTS],
  input  axi_data_t  mst_r_data_i [NUM_MST_PORTS],
  input  port_mask_t mst_r_last_i,
  input  port_mask_t mst_r_valid_i,
  output port_mask_t mst_r_ready_o,
  output axi_id_t    slv_r_id_o,
  output axi_data_t  slv_r_data_o,
  output logic       slv_r_last_o,
  output logic       slv_r_valid_o,
  input  logic       slv_r_ready_i,
  output logic       r_pop_o,
  output look_id_t   pop_id_o
);

  port_sel_t rr_q;
  port_sel_t pick_idx;
  port_sel_t gnt_idx;
  port_sel_t lock_idx_q;
  logic      lock_q;
  logic      beat_done;

  // ------------------------------------------------------------------
  // arbitration
  // ------------------------------------------------------------------
  // first valid port at or after the pointer
  always_comb begin
    int unsigned cand;
    logic        found;
    found    = 1'b0;
    pick_idx = '0;
    for (int unsigned k = 0; k < NUM_MST_PORTS; k++) begin
      cand = (rr_q + k) % NUM_MST_PORTS;
      if (!found && mst_r_valid_i[cand]) begin
        found    = 1'b1;
        pick_idx = port_sel_t'(cand);
      end
    end
  end

  assign gnt_idx = lock_q ? lock_idx_q : pick_idx;

  // ------------------------------------------------------------------
  // beat forwarding
  // ------------------------------------------------------------------
  assign slv_r_valid_o = mst_r_valid_i[gnt_idx];
  assign slv_r_id_o    = mst_r_id_i[gnt_idx];
  assign slv_r_data_o  = mst_r_data_i[gnt_idx];
  assign slv_r_last_o  = mst_r_last_i[gnt_idx];

  assign mst_r_ready_o = slv_r_valid_o ? (port_mask_t'(slv_r_ready_i) << gnt_idx) : '0;
  assign beat_done     = slv_r_valid_o && slv_r_ready_i;

  // end of a burst frees one slot of its ID
  assign r_pop_o  = beat_done && slv_r_last_o;
  assign pop_id_o = look_id_t'(slv_r_id_o[ID_LOOK_BITS-1:0]);

  // ------------------------------------------------------------------
  // grant lock and pointer
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      rr_q       <= '0;
    end else begin
      lock_q     <= slv_r_valid_o && !slv_r_ready_i;
      lock_idx_q <= gnt_idx;
      if (beat_done) begin
        // next search starts just past the port that was served
        rr_q <= (gnt_idx == port_sel_t'(NUM_MST_PORTS - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- axi_rd_demux.sv
/*
  Read-only AXI demux, one upstream port to NUM_MST_PORTS downstream ports.
  slv_ar_sel_i picks the port and must hold while slv_ar_valid_i is high.
  Reads with equal low ID bits to different ports are serialized.
*/

`timescale 1ns/1ps
`default_nettype none

module axi_rd_demux
  import axi_rd_pkg::*;
  import demux_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // upstream AR
  input  axi_id_t    slv_ar_id_i,
  input  axi_addr_t  slv_ar_addr_i,
  input  axi_len_t   slv_ar_len_i,
  input  port_sel_t  slv_ar_sel_i,
  input  logic       slv_ar_valid_i,
  output logic       slv_ar_ready_o,
  // upstream R
  output axi_id_t    slv_r_id_o,
  output axi_data_t  slv_r_data_o,
  output logic       slv_r_last_o,
  output logic       slv_r_valid_o,
  input  logic       slv_r_ready_i,
  // downstream AR
  output axi_id_t    mst_ar_id_o   [NUM_MST_PORTS],
  output axi_addr_t  mst_ar_addr_o [NUM_MST_PORTS],
  output axi_len_t   mst_ar_len_o  [NUM_MST_PORTS],
  output port_mask_t mst_ar_valid_o,
  input  port_mask_t mst_ar_ready_i,
  // downstream R
  input  axi_id_t    mst_r_id_i    [NUM_MST_PORTS],
  input  axi_data_t  mst_r_data_i  [NUM_MST_PORTS],
  input  port_mask_t mst_r_last_i,
  input  port_mask_t mst_r_valid_i,
  output port_mask_t mst_r_ready_o
);

  logic     r_pop;
  look_id_t pop_id;

  id_track_if trk_if ();

  // ------------------------------------------------------------------
  // AR path
  // ------------------------------------------------------------------
  // payload goes to every port, only the valid is steered
  for (genvar p = 0; p < NUM_MST_PORTS; p++) begin : gen_ar_bcast
    assign mst_ar_id_o[p]   = slv_ar_id_i;
    assign mst_ar_addr_o[p] = slv_ar_addr_i;
    assign mst_ar_len_o[p]  = slv_ar_len_i;
  end

  demux_ar_route u_ar_route (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .trk            (trk_if.router),
    .slv_ar_id_i    (slv_ar_id_i),
    .slv_ar_sel_i   (slv_ar_sel_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i)
  );

  // ------------------------------------------------------------------
  // ID tracking
  // ------------------------------------------------------------------
  demux_id_tracker u_id_tracker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .trk      (trk_if.tracker),
    .r_pop_i  (r_pop),
    .pop_id_i (pop_id)
  );

  // ------------------------------------------------------------------
  // R path
  // ------------------------------------------------------------------
  demux_r_merge u_r_merge (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mst_r_id_i    (mst_r_id_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_last_i  (mst_r_last_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_id_o    (slv_r_id_o),
    .slv_r_data_o  (slv_r_data_o),
    .slv_r_last_o  (slv_r_last_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i),
    .r_pop_o       (r_pop),
    .pop_id_o      (pop_id)
  );

endmodule

`default_nettype wire

//--- tb_axi_rd_demux.sv
/*
  Self-checking testbench for the read demux. AR rows come from a table.
  Each port has a responder model that returns len+1 beats per read.
  Upstream R ready and downstream AR ready are randomized.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_demux
  import axi_rd_pkg::*;
  import demux_cfg_pkg::*;
();

  localparam int unsigned NUM_ROWS       = 18;
  localparam int unsigned TIMEOUT_CYCLES = 200 * NUM_ROWS;
  localparam int unsigned AR_W           = ID_WIDTH + LEN_WIDTH;

  logic       clk;
  logic       rst_n;
  axi_id_t    slv_ar_id_i;
  axi_addr_t  slv_ar_addr_i;
  axi_len_t   slv_ar_len_i;
  port_sel_t  slv_ar_sel_i;
  logic       slv_ar_valid_i;
  logic       slv_ar_ready_o;
  axi_id_t    slv_r_id_o;
  axi_data_t  slv_r_data_o;
  logic       slv_r_last_o;
  logic       slv_r_valid_o;
  logic       slv_r_ready_i;
  axi_id_t    mst_ar_id_o   [NUM_MST_PORTS];
  axi_addr_t  mst_ar_addr_o [NUM_MST_PORTS];
  axi_len_t   mst_ar_len_o  [NUM_MST_PORTS];
  port_mask_t mst_ar_valid_o;
  port_mask_t mst_ar_ready_i;
  axi_id_t    mst_r_id_i    [NUM_MST_PORTS];
  axi_data_t  mst_r_data_i  [NUM_MST_PORTS];
  port_mask_t mst_r_last_i;
  port_mask_t mst_r_valid_i;
  port_mask_t mst_r_ready_o;

  // stimulus table
  string       row_name [NUM_ROWS];
  axi_id_t     row_id   [NUM_ROWS];
  port_sel_t   row_sel  [NUM_ROWS];
  axi_len_t    row_len  [NUM_ROWS];
  port_sel_t   row_port [NUM_ROWS];
  logic        row_stall[NUM_ROWS];
  logic        row_hold [NUM_ROWS];
  logic        row_drain[NUM_ROWS];
  logic        row_rel  [NUM_ROWS];

  // responder and scoreboard state
  logic [AR_W-1:0]         ar_q   [NUM_MST_PORTS][$];
  logic [DATA_WIDTH:0]     exp_q  [2**ID_WIDTH][$];
  int unsigned             beat_n [NUM_MST_PORTS];
  int unsigned             gap    [NUM_MST_PORTS];
  port_mask_t              hold_r;
  port_mask_t              r_fire;
  int unsigned             cnt_m  [NUM_COUNTERS];
  port_sel_t               port_m [NUM_COUNTERS];
  int unsigned             outstanding;
  logic                    bp_pending;
  logic [ID_WIDTH+DATA_WIDTH+1:0] held_beat;
  string                   cur_name;
  int unsigned             n_checks;
  int unsigned             n_errors;
  int unsigned             cycles;

  axi_rd_demux dut0 (.clk_i(clk), .rst_ni(rst_n), .*);

  always #10 clk = ~clk;

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h", cur_name, what, exp, act);
      n_errors++;
    end
  endtask

  // id in the upper half so bursts of different ids never look alike
  function automatic axi_data_t beat_data(input axi_id_t id, input int unsigned beat);
    beat_data = {4'hc, id, 8'h5a, 16'(beat)};
  endfunction

  task automatic add_row(input int r, input string name, input axi_id_t id, input port_sel_t sel,
                         input axi_len_t len, input port_sel_t port, input logic stall,
                         input logic hold, input logic drain, input logic rel);
    row_name[r]  = name;
    row_id[r]    = id;
    row_sel[r]   = sel;
    row_len[r]   = len;
    row_port[r]  = port;
    row_stall[r] = stall;
    row_hold[r]  = hold;
    row_drain[r] = drain;
    row_rel[r]   = rel;
  endtask

  task automatic run_row(input int r);
    port_mask_t  onehot;
    logic        first;
    int unsigned err0;
    cur_name = row_name[r];
    err0     = n_errors;
    onehot   = port_mask_t'(1) << row_port[r];
    if (row_drain[r]) begin
      while (outstanding != 0) @(posedge clk);
    end
    @(posedge clk);
    slv_ar_id_i    <= row_id[r];
    slv_ar_addr_i  <= 32'h1000_0000 + 32'(r) * 32'h40;
    slv_ar_len_i   <= row_len[r];
    slv_ar_sel_i   <= row_sel[r];
    slv_ar_valid_i <= 1'b1;
    if (row_hold[r]) hold_r[row_sel[r]] <= 1'b1;
    if (row_stall[r]) begin
      repeat (6) begin
        @(negedge clk);
        check_value("ar valid while stalled", 0, mst_ar_valid_o);
        check_value("ar ready while stalled", 0, slv_ar_ready_o);
      end
      // let the held bursts finish so the stall can clear
      @(posedge clk);
      hold_r <= '0;
    end
    first = 1'b1;
    do begin
      @(negedge clk);
      if (first && !row_stall[r]) check_value("ar valid at once", onehot, mst_ar_valid_o);
      first = 1'b0;
    end while (!slv_ar_ready_o);
    check_value("ar valid port", onehot, mst_ar_valid_o);
    check_value("ar id", row_id[r], mst_ar_id_o[row_port[r]]);
    check_value("ar addr", 32'h1000_0000 + 32'(r) * 32'h40, mst_ar_addr_o[row_port[r]]);
    check_value("ar len", row_len[r], mst_ar_len_o[row_port[r]]);
    @(posedge clk);
    slv_ar_valid_i <= 1'b0;
    if (row_rel[r]) hold_r <= '0;
    $display("test %0d %s done, %0d errors", r, cur_name, n_errors - err0);
  endtask

  // ------------------------------------------------------------------
  // port responders driven on the rising edge
  // ------------------------------------------------------------------
  always @(posedge clk) begin : responders
    logic [AR_W-1:0] head;
    if (rst_n) begin
      mst_ar_ready_i <= port_mask_t'($urandom);
      slv_r_ready_i  <= ($urandom % 4) != 0;
      for (int p = 0; p < NUM_MST_PORTS; p++) begin
        if (r_fire[p]) begin
          head = ar_q[p][0];
          mst_r_valid_i[p] <= 1'b0;
          if (beat_n[p] == head[LEN_WIDTH-1:0]) begin
            void'(ar_q[p].pop_front());
            beat_n[p] = 0;
          end else begin
            beat_n[p]++;
          end
          gap[p] = $urandom % 3;
        end else if (!mst_r_valid_i[p] && ar_q[p].size() != 0 && !hold_r[p]) begin
          head = ar_q[p][0];
          if (gap[p] != 0) begin
            gap[p]--;
          end else begin
            mst_r_valid_i[p] <= 1'b1;
            mst_r_id_i[p]    <= head[AR_W-1:LEN_WIDTH];
            mst_r_data_i[p]  <= beat_data(head[AR_W-1:LEN_WIDTH], beat_n[p]);
            mst_r_last_i[p]  <= (beat_n[p] == head[LEN_WIDTH-1:0]);
          end
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // monitor and scoreboard sampled on the falling edge
  // ------------------------------------------------------------------
  always @(negedge clk) begin : monitor
    logic [DATA_WIDTH:0] e;
    axi_id_t             rid;
    logic                allowed;
    logic                full_m;
    int unsigned         low;
    r_fire = rst_n ? (mst_r_valid_i & mst_r_ready_o) : '0;
    if (rst_n) begin
      if (!slv_ar_valid_i) check_value("ar valid without request", 0, mst_ar_valid_o);
      // AR handshakes judged against the counts before this edge
      for (int p = 0; p < NUM_MST_PORTS; p++) begin
        if (mst_ar_valid_o[p] && mst_ar_ready_i[p]) begin
          low    = mst_ar_id_o[p][ID_LOOK_BITS-1:0];
          full_m = 1'b0;
          for (int c = 0; c < NUM_COUNTERS; c++) full_m |= (cnt_m[c] >= 7);
          allowed = !full_m && (cnt_m[low] == 0 || port_m[low] == port_sel_t'(p));
          check_value("ar allowed by id rule", 1, allowed);
          ar_q[p].push_back({mst_ar_id_o[p], mst_ar_len_o[p]});
          for (int b = 0; b <= mst_ar_len_o[p]; b++) begin
            exp_q[mst_ar_id_o[p]].push_back({b == mst_ar_len_o[p],
                                             beat_data(mst_ar_id_o[p], b)});
          end
          cnt_m[low]++;
          port_m[low] = port_sel_t'(p);
          outstanding++;
        end
      end
      // back-pressure keeps the presented beat
      if (!slv_r_ready_i) check_value("r ready under back-pressure", 0, mst_r_ready_o);
      if (bp_pending) begin
        check_value("held beat", held_beat,
                    {slv_r_valid_o, slv_r_last_o, slv_r_id_o, slv_r_data_o});
      end
      bp_pending = slv_r_valid_o && !slv_r_ready_i;
      held_beat  = {1'b1, slv_r_last_o, slv_r_id_o, slv_r_data_o};
      if (slv_r_valid_o && slv_r_ready_i) begin
        rid = slv_r_id_o;
        if (exp_q[rid].size() == 0) begin
          $display("unexpected R beat with id %0h, no burst is outstanding for it", rid);
          n_errors++;
        end else begin
          e = exp_q[rid].pop_front();
          check_value("r data", e[DATA_WIDTH-1:0], slv_r_data_o);
          check_value("r last", e[DATA_WIDTH], slv_r_last_o);
          if (slv_r_last_o) begin
            cnt_m[rid[ID_LOOK_BITS-1:0]]--;
            outstanding--;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    void'($urandom(58547));
    clk = 1'b0;
    rst_n = 1'b0;
    slv_ar_id_i = '0;
    slv_ar_addr_i = '0;
    slv_ar_len_i = '0;
    slv_ar_sel_i = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i = 1'b0;
    mst_ar_ready_i = '0;
    mst_r_last_i = '0;
    mst_r_valid_i = '0;
    hold_r = '0;
    r_fire = '0;
    bp_pending = 1'b0;
    held_beat = '0;
    outstanding = 0;
    n_checks = 0;
    n_errors = 0;
    cycles = 0;
    cur_name = "reset";
    for (int p = 0; p < NUM_MST_PORTS; p++) begin
      mst_r_id_i[p] = '0;
      mst_r_data_i[p] = '0;
      beat_n[p] = 0;
      gap[p] = 0;
    end
    for (int c = 0; c < NUM_COUNTERS; c++) begin
      cnt_m[c] = 0;
      port_m[c] = '0;
    end
    //           name                  id    sel   len   port  st    hold  drain rel
    add_row(0,  "route_p0",           4'h0, 2'd0, 8'd0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1,  "route_p1",           4'h1, 2'd1, 8'd3, 2'd1, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(2,  "route_p2",           4'h2, 2'd2, 8'd1, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(3,  "same_id_same_port",  4'h5, 2'd1, 8'd2, 2'd1, 1'b0, 1'b0, 1'b0, 1'b1);
    add_row(4,  "hold_first",         4'h3, 2'd0, 8'd2, 2'd0, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(5,  "same_id_other_port", 4'h7, 2'd2, 8'd0, 2'd2, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(6,  "merge_a",            4'h4, 2'd0, 8'd3, 2'd0, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row(7,  "merge_b",            4'h9, 2'd1, 8'd3, 2'd1, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(8,  "merge_c",            4'he, 2'd2, 8'd3, 2'd2, 1'b0, 1'b1, 1'b0, 1'b1);
    for (int r = 9; r < 16; r++) begin
      add_row(r, "fill_counter",      4'h6, 2'd0, 8'd0, 2'd0, 1'b0, 1'b1, r == 9, 1'b0);
    end
    add_row(16, "capacity_stall",     4'h1, 2'd1, 8'd1, 2'd1, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(17, "after_capacity",     4'hb, 2'd2, 8'd2, 2'd2, 1'b0, 1'b0, 1'b1, 1'b0);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int r = 0; r < NUM_ROWS; r++) run_row(r);
    while (outstanding != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    cur_name = "final_drain";
    for (int i = 0; i < 2**ID_WIDTH; i++) check_value("leftover beats", 0, exp_q[i].size());
    $display("summary: %0d tests, %0d checks, %0d errors", NUM_ROWS, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- axi_rd_demux.f
axi_rd_pkg.sv
demux_cfg_pkg.sv
id_track_if.sv
demux_id_tracker.sv
demux_ar_route.sv
demux_r_merge.sv
axi_rd_demux.sv
tb_axi_rd_demux.sv
